/* source/cpu_pkg.sv */
package cpu_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    typedef logic [15:0] word_t;       // Data and instruction word
    typedef logic [2:0]  reg_idx_t;    // r0 to r7
    typedef logic [5:0]  imem_addr_t;  // Program counter width
    typedef logic [7:0]  dmem_addr_t;  // Data address, also sp

    // Opcode field, bits 15:11
    typedef enum logic [4:0] {
        op_nop  = 5'b00000,
        op_hlt  = 5'b00010,
        op_not  = 5'b00100,
        op_ldm  = 5'b00101,
        op_push = 5'b01000,
        op_pop  = 5'b01001,
        op_ldd  = 5'b01010,
        op_std  = 5'b01100,
        op_rti  = 5'b10110,
        op_add  = 5'b11001,
        op_sub  = 5'b11010
    } opcode_t;

    // Execute stage FSM
    typedef enum logic [1:0] {
        x_run,
        x_mem_wait,
        x_irq_push,
        x_halted
    } core_state_t;

    localparam imem_addr_t reset_vector = 6'd32;
    localparam imem_addr_t irq_vector   = 6'd0;
    localparam dmem_addr_t stack_top    = 8'd255;
    localparam int         imem_depth   = 64;
    localparam int         dmem_depth   = 256;

    //////////////////////////////////////////////////////////////////////
    // Instruction fields
    //////////////////////////////////////////////////////////////////////

    function automatic opcode_t f_opcode(word_t ir);
        return opcode_t'(ir[15:11]);  // Unknown codes fall to NOP in decode
    endfunction

    function automatic reg_idx_t f_rs(word_t ir);
        return ir[10:8];
    endfunction

    function automatic reg_idx_t f_rd(word_t ir);
        return ir[7:5];
    endfunction

endpackage

/* source/data_bus_if.sv */
`timescale 1ns/1ps

// Wishbone classic, core to data memory
interface data_bus_if import cpu_pkg::*; ();

    logic       cyc;
    logic       stb;
    logic       we;
    dmem_addr_t adr;
    word_t      dat_w;
    word_t      dat_r;
    logic       ack;

    modport master (
        output cyc,
        output stb,
        output we,
        output adr,
        output dat_w,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  adr,
        input  dat_w,
        output dat_r,
        output ack
    );

endinterface

/* source/instr_mem.sv */
`timescale 1ns/1ps

module instr_mem import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst_fm,
    input  logic        write_enable_fm,
    input  logic [31:0] write_addr_fm,
    input  word_t       write_data_fm,
    input  imem_addr_t  fetch_addr,
    output word_t       fetch_data
);

    word_t      mem [imem_depth];
    imem_addr_t load_addr;

    // Only the low bits of the load address reach the array
    assign load_addr = write_addr_fm[$bits(imem_addr_t)-1:0];

    //////////////////////////////////////////////////////////////////////
    // Load port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_fm) begin
            for (int i = 0; i < imem_depth; i++) begin
                mem[i] <= '0;  // All NOP
            end
        end else if (write_enable_fm) begin
            mem[load_addr] <= write_data_fm;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Fetch
    //////////////////////////////////////////////////////////////////////

    // Asynchronous read so the PC and the word line up in one cycle
    assign fetch_data = mem[fetch_addr];

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    output word_t    rs_data,
    output word_t    rt_data,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data,
    input  reg_idx_t dbg_idx,
    output word_t    dbg_data
);

    word_t regs [8];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Write in flight wins over the stored value
    function automatic word_t read_port(reg_idx_t idx, logic we, reg_idx_t widx,
                                        word_t wdata, word_t stored);
        return (we && widx == idx) ? wdata : stored;
    endfunction

    // Decode ports and debug port all see the same-cycle write
    always_comb begin
        rs_data  = read_port(rs_idx, wr_en, wr_idx, wr_data, regs[rs_idx]);
        rt_data  = read_port(rt_idx, wr_en, wr_idx, wr_data, regs[rt_idx]);
        dbg_data = read_port(dbg_idx, wr_en, wr_idx, wr_data, regs[dbg_idx]);
    end

endmodule

/* source/data_mem.sv */
`timescale 1ns/1ps

module data_mem import cpu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    data_bus_if.slave  bus
);

    word_t mem [dmem_depth];  // Data and stack share the array
    logic  req_new;           // Strobe seen, not yet acked

    assign req_new = bus.cyc && bus.stb && !bus.ack;

    //////////////////////////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////////////////////////

    // One-cycle ack, falls back as soon as the strobe goes
    always_ff @(posedge clk) begin
        if (reset) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= req_new;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Array
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (req_new) begin
            bus.dat_r <= mem[bus.adr];  // Ready together with ack
        end
        if (bus.cyc && bus.stb && bus.we && bus.ack) begin
            mem[bus.adr] <= bus.dat_w;  // Commit on the acknowledging edge
        end
    end

endmodule

/* source/pipe_core.sv */
`timescale 1ns/1ps

module pipe_core import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    output imem_addr_t  fetch_addr,
    input  word_t       fetch_data,
    output reg_idx_t    rs_idx,
    output reg_idx_t    rt_idx,
    input  word_t       rs_data,
    input  word_t       rt_data,
    output logic        wr_en,
    output reg_idx_t    wr_idx,
    output word_t       wr_data,
    data_bus_if.master  bus,
    input  logic        interrupt,
    output word_t       instruction
);

    core_state_t state, state_next;
    imem_addr_t  pc;
    dmem_addr_t  sp;
    logic        irq_pending;
    logic        in_isr;        // No nesting

    // Fetch/decode register
    logic        fd_valid;
    word_t       fd_ir;
    imem_addr_t  fd_pc;

    // Decode/execute register
    logic        de_valid;
    word_t       de_ir;
    word_t       de_rs_val;
    word_t       de_rd_val;

    opcode_t     de_op;
    word_t       alu_out;
    logic        alu_writes;
    logic        is_mem;
    logic        retire;        // Execute finishes its instruction
    logic        take_irq;
    logic        rti_done;
    logic        push_done;
    logic        advance;       // Fetch and decode move on
    logic        flush;
    logic        bus_req;
    logic        bus_we;
    dmem_addr_t  bus_adr;
    word_t       bus_dat;

    assign fetch_addr  = pc;
    assign rs_idx      = f_rs(fd_ir);
    assign rt_idx      = f_rd(fd_ir);  // rd doubles as second source
    assign wr_idx      = f_rd(de_ir);
    assign de_op       = f_opcode(de_ir);
    assign instruction = de_valid ? de_ir : '0;

    //////////////////////////////////////////////////////////////////////
    // Decode of the execute word and ALU
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        alu_out    = de_rd_val;
        alu_writes = 1'b1;
        case (de_op)
            op_ldm:  alu_out = {11'd0, de_ir[4:0]};
            op_not:  alu_out = ~de_rs_val;
            op_add:  alu_out = de_rd_val + de_rs_val;
            op_sub:  alu_out = de_rd_val - de_rs_val;
            default: alu_writes = 1'b0;
        endcase
    end

    assign is_mem = de_op inside {op_push, op_pop, op_ldd, op_std, op_rti};

    //////////////////////////////////////////////////////////////////////
    // Execute FSM
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        retire     = 1'b0;
        bus_req    = 1'b0;
        wr_en      = 1'b0;
        wr_data    = alu_out;
        case (state)
            x_run: begin
                if (de_valid) begin
                    if (is_mem) begin
                        bus_req    = 1'b1;  // Strobe goes out at once
                        state_next = x_mem_wait;
                    end else if (de_op == op_hlt) begin
                        state_next = x_halted;
                    end else begin
                        retire = 1'b1;
                        wr_en  = alu_writes;
                    end
                end
            end
            x_mem_wait: begin
                bus_req = 1'b1;
                if (bus.ack) begin
                    retire     = 1'b1;
                    wr_en      = (de_op == op_pop) || (de_op == op_ldd);
                    wr_data    = bus.dat_r;
                    state_next = x_run;
                end
            end
            x_irq_push: begin
                bus_req = 1'b1;
                if (bus.ack) begin
                    state_next = x_run;
                end
            end
            default: ;  // Halted until reset
        endcase

        rti_done  = retire && (de_op == op_rti);
        take_irq  = retire && irq_pending && !rti_done;
        push_done = (state == x_irq_push) && bus.ack;
        if (take_irq) begin
            state_next = x_irq_push;
        end
    end

    assign flush   = take_irq || rti_done;
    assign advance = ((state == x_run) && !de_valid) || (retire && !flush);

    //////////////////////////////////////////////////////////////////////
    // Bus master
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        bus_we  = 1'b0;
        bus_adr = sp;
        bus_dat = de_rs_val;
        if (state == x_irq_push) begin
            bus_we  = 1'b1;
            bus_dat = {10'd0, pc};  // Return address
        end else begin
            case (de_op)
                op_push: bus_we = 1'b1;
                op_pop, op_rti: bus_adr = sp + 8'd1;
                op_ldd: bus_adr = de_rs_val[7:0];
                op_std: begin
                    bus_we  = 1'b1;
                    bus_adr = de_rd_val[7:0];
                end
                default: ;
            endcase
        end
    end

    assign bus.cyc   = bus_req;
    assign bus.stb   = bus_req;
    assign bus.we    = bus_we;
    assign bus.adr   = bus_adr;
    assign bus.dat_w = bus_dat;

    //////////////////////////////////////////////////////////////////////
    // Control registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= x_run;
            pc          <= reset_vector;
            sp          <= stack_top;
            fd_valid    <= 1'b0;
            de_valid    <= 1'b0;
            irq_pending <= 1'b0;
            in_isr      <= 1'b0;
        end else begin
            state <= state_next;

            if (push_done) begin
                pc <= irq_vector;
            end else if (rti_done) begin
                pc <= bus.dat_r[5:0];
            end else if (take_irq) begin
                pc <= fd_valid ? fd_pc : pc;  // Oldest flushed instruction
            end else if (advance) begin
                pc <= pc + 6'd1;
            end

            if (push_done || (retire && de_op == op_push)) begin
                sp <= sp - 8'd1;
            end else if (retire && (de_op == op_pop || rti_done)) begin
                sp <= sp + 8'd1;
            end

            if (flush) begin
                fd_valid <= 1'b0;
                de_valid <= 1'b0;
            end else if (advance) begin
                fd_valid <= 1'b1;
                de_valid <= fd_valid;
            end

            if (take_irq) begin
                irq_pending <= 1'b0;
            end else if (interrupt && !in_isr && state != x_halted) begin
                irq_pending <= 1'b1;
            end

            if (take_irq) begin
                in_isr <= 1'b1;
            end else if (rti_done) begin
                in_isr <= 1'b0;
            end
        end
    end

    // Pipeline payload
    always_ff @(posedge clk) begin
        if (advance) begin
            fd_ir     <= fetch_data;
            fd_pc     <= pc;
            de_ir     <= fd_ir;
            de_rs_val <= rs_data;
            de_rd_val <= rt_data;
        end
    end

endmodule

/* source/pipelined_processor.sv */
`timescale 1ns/1ps

module pipelined_processor import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  reg_idx_t    write_addr,
    output word_t       result,
    input  logic        write_enable_fm,
    input  logic        rst_fm,
    input  word_t       write_data_fm,
    input  logic [31:0] write_addr_fm,
    output word_t       instruction,
    input  logic        interrupt
);

    imem_addr_t fetch_addr;
    word_t      fetch_data;
    reg_idx_t   rs_idx;
    reg_idx_t   rt_idx;
    word_t      rs_data;
    word_t      rt_data;
    logic       wr_en;
    reg_idx_t   wr_idx;
    word_t      wr_data;

    data_bus_if dbus ();  // Core to data memory

    instr_mem u_instr_mem (
        .clk             (clk),
        .rst_fm          (rst_fm),
        .write_enable_fm (write_enable_fm),
        .write_addr_fm   (write_addr_fm),
        .write_data_fm   (write_data_fm),
        .fetch_addr      (fetch_addr),
        .fetch_data      (fetch_data)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs_idx   (rs_idx),
        .rt_idx   (rt_idx),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .dbg_idx  (write_addr),
        .dbg_data (result)      // Debug readout
    );

    data_mem u_data_mem (
        .clk   (clk),
        .reset (reset),
        .bus   (dbus.slave)
    );

    pipe_core u_pipe_core (
        .clk         (clk),
        .reset       (reset),
        .fetch_addr  (fetch_addr),
        .fetch_data  (fetch_data),
        .rs_idx      (rs_idx),
        .rt_idx      (rt_idx),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data),
        .bus         (dbus.master),
        .interrupt   (interrupt),
        .instruction (instruction)
    );

endmodule

/* tb/pipelined_processor_assert.sv */
`timescale 1ns/1ps

module pipelined_processor_assert (
    input logic        clk,
    input logic        reset,
    input logic        cyc,
    input logic        stb,
    input logic        ack,
    input logic [7:0]  adr,
    input logic [15:0] instruction
);

    a_stb_in_cycle: assert property (@(posedge clk) disable iff (reset) stb |-> cyc)
        else $error("stb high without cyc");

    a_ack_with_stb: assert property (@(posedge clk) disable iff (reset) ack |-> stb)
        else $error("ack high without stb");

    // Request held until acknowledged
    a_hold_request: assert property (@(posedge clk) disable iff (reset)
        stb && !ack |=> stb && $stable(adr))
        else $error("request dropped or address changed before ack");

    a_reset_quiet: assert property (@(posedge clk)
        $fell(reset) |-> instruction == 16'd0 && !cyc)
        else $error("core not idle right after reset");

endmodule

bind pipelined_processor pipelined_processor_assert u_assert (
    .clk         (clk),
    .reset       (reset),
    .cyc         (dbus.cyc),
    .stb         (dbus.stb),
    .ack         (dbus.ack),
    .adr         (dbus.adr),
    .instruction (instruction)
);

/* tb/pipelined_processor_tb.sv */
`timescale 1ns/1ps

module pipelined_processor_tb;

    localparam logic [4:0]  c_nop  = 5'b00000;
    localparam logic [4:0]  c_hlt  = 5'b00010;
    localparam logic [4:0]  c_not  = 5'b00100;
    localparam logic [4:0]  c_ldm  = 5'b00101;
    localparam logic [4:0]  c_push = 5'b01000;
    localparam logic [4:0]  c_pop  = 5'b01001;
    localparam logic [4:0]  c_ldd  = 5'b01010;
    localparam logic [4:0]  c_std  = 5'b01100;
    localparam logic [4:0]  c_rti  = 5'b10110;
    localparam logic [4:0]  c_add  = 5'b11001;
    localparam logic [4:0]  c_sub  = 5'b11010;
    localparam logic [15:0] hlt_word = 16'h1000;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic [2:0]  write_addr = 3'd0;
    logic [15:0] result;
    logic        write_enable_fm = 1'b0;
    logic        rst_fm = 1'b0;
    logic [15:0] write_data_fm = 16'd0;
    logic [31:0] write_addr_fm = 32'd0;
    logic [15:0] instruction;
    logic        interrupt = 1'b0;

    // Program image and model state
    logic [15:0] prog [64];
    logic [15:0] mregs [8];
    logic [15:0] mmem [256];
    logic [7:0]  msp;
    int          seed = 57;
    int          errors = 0;
    int          tests = 0;
    int          passed = 0;
    int          test_errors;

    pipelined_processor uut (
        .clk             (clk),
        .reset           (reset),
        .write_addr      (write_addr),
        .result          (result),
        .write_enable_fm (write_enable_fm),
        .rst_fm          (rst_fm),
        .write_data_fm   (write_data_fm),
        .write_addr_fm   (write_addr_fm),
        .instruction     (instruction),
        .interrupt       (interrupt)
    );

    always #5 clk = ~clk;

    function automatic logic [15:0] enc(input logic [4:0] op, input logic [2:0] rs,
                                        input logic [2:0] rd, input logic [4:0] imm);
        return {op, rs, rd, imm};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model with in-order execution until HLT
    //////////////////////////////////////////////////////////////////////

    function automatic void model_run(input bit with_irq);
        logic [5:0]  pc;
        logic [15:0] ir;
        logic [2:0]  rs;
        logic [2:0]  rd;
        for (int i = 0; i < 8; i++) begin
            mregs[i] = 16'd0;
        end
        msp = 8'd255;
        pc  = 6'd32;
        // Whole ISR runs up front since registers are disjoint
        if (with_irq) begin
            mmem[msp] = {10'd0, pc};
            msp = msp - 8'd1;
            pc = 6'd0;
        end
        for (int steps = 0; steps < 1000; steps++) begin
            ir = prog[pc];
            rs = ir[10:8];
            rd = ir[7:5];
            pc = pc + 6'd1;
            if (ir[15:11] == c_hlt) begin
                break;
            end
            case (ir[15:11])
                c_ldm:  mregs[rd] = {11'd0, ir[4:0]};
                c_not:  mregs[rd] = ~mregs[rs];
                c_add:  mregs[rd] = mregs[rd] + mregs[rs];
                c_sub:  mregs[rd] = mregs[rd] - mregs[rs];
                c_push: begin
                    mmem[msp] = mregs[rs];
                    msp = msp - 8'd1;
                end
                c_pop: begin
                    msp = msp + 8'd1;
                    mregs[rd] = mmem[msp];
                end
                c_ldd:  mregs[rd] = mmem[mregs[rs][7:0]];
                c_std:  mmem[mregs[rd][7:0]] = mregs[rs];
                c_rti: begin
                    msp = msp + 8'd1;
                    pc = mmem[msp][5:0];
                end
                default: ;  // NOP and undefined codes
            endcase
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////////////////////////

    task automatic clear_prog();
        for (int i = 0; i < 64; i++) begin
            prog[i] = 16'd0;
        end
    endtask

    // Program goes in under reset and reset is released afterwards
    task automatic load_program();
        @(posedge clk);
        reset  <= 1'b1;
        rst_fm <= 1'b1;
        @(posedge clk);
        rst_fm <= 1'b0;
        for (int i = 0; i < 64; i++) begin
            @(posedge clk);
            write_enable_fm <= 1'b1;
            write_addr_fm   <= i;
            write_data_fm   <= prog[i];
        end
        @(posedge clk);
        write_enable_fm <= 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_halt(output bit ok);
        ok = 1'b0;
        for (int c = 0; c < 2000; c++) begin
            @(negedge clk);
            if (instruction === hlt_word) begin
                ok = 1'b1;
                break;
            end
        end
    endtask

    task automatic check_regs(input string name);
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            write_addr <= 3'(i);
            @(negedge clk);
            assert (result === mregs[i]) else begin
                $display("ERROR %s r%0d expected %h actual %h", name, i, mregs[i], result);
                test_errors++;
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (test_errors == 0) begin
            passed++;
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, test_errors);
        end
        errors += test_errors;
    endtask

    task automatic run_program(input string name, input bit with_irq);
        bit ok;
        test_errors = 0;
        model_run(with_irq);
        load_program();
        if (with_irq) begin
            repeat (6) @(posedge clk);
            interrupt <= 1'b1;
            @(posedge clk);
            interrupt <= 1'b0;
        end
        wait_halt(ok);
        if (!ok) begin
            $display("%s: processor never reached HLT", name);
            test_errors++;
        end else begin
            check_regs(name);
        end
        finish_test(name);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        logic [4:0]  op;
        int          depth;

        clear_prog();
        prog[32] = enc(c_ldm, 3'd0, 3'd1, 5'd7);
        prog[33] = enc(c_ldm, 3'd0, 3'd2, 5'd3);
        prog[34] = enc(c_add, 3'd2, 3'd1, 5'd0);  // Back to back
        prog[35] = enc(c_sub, 3'd1, 3'd2, 5'd0);
        prog[36] = enc(c_not, 3'd2, 3'd3, 5'd0);
        prog[37] = enc(c_add, 3'd3, 3'd3, 5'd0);
        prog[38] = enc(c_sub, 3'd3, 3'd4, 5'd0);
        prog[39] = enc(c_ldm, 3'd0, 3'd5, 5'd31);
        prog[40] = enc(c_add, 3'd1, 3'd5, 5'd0);
        prog[41] = hlt_word;
        run_program("alu_program", 1'b0);

        // Empty memory runs NOPs forever
        test_errors = 0;
        clear_prog();
        load_program();
        for (int i = 0; i < 8; i++) begin
            mregs[i] = 16'd0;
        end
        repeat (4) @(negedge clk);
        assert (instruction === 16'd0) else begin
            $display("ERROR reset_state instruction expected %h actual %h", 16'd0, instruction);
            test_errors++;
        end
        check_regs("reset_state");
        finish_test("reset_state");

        clear_prog();
        prog[32] = enc(c_ldm, 3'd0, 3'd1, 5'd5);
        prog[33] = enc(c_ldm, 3'd0, 3'd2, 5'd10);
        prog[34] = enc(c_std, 3'd1, 3'd2, 5'd0);
        prog[35] = enc(c_ldd, 3'd2, 3'd3, 5'd0);  // Read right after write
        prog[36] = enc(c_push, 3'd3, 3'd0, 5'd0);
        prog[37] = enc(c_push, 3'd2, 3'd0, 5'd0);
        prog[38] = enc(c_pop, 3'd0, 3'd4, 5'd0);
        prog[39] = enc(c_pop, 3'd0, 3'd5, 5'd0);
        prog[40] = enc(c_add, 3'd4, 3'd5, 5'd0);
        prog[41] = enc(c_ldm, 3'd0, 3'd6, 5'd30);
        prog[42] = enc(c_std, 3'd5, 3'd6, 5'd0);
        prog[43] = enc(c_ldd, 3'd6, 3'd7, 5'd0);
        prog[44] = hlt_word;
        run_program("memory_stack", 1'b0);

        // ISR at 0 on r5 to r7 and main at 32 on r1 to r3
        clear_prog();
        prog[0] = enc(c_ldm, 3'd0, 3'd5, 5'd7);
        prog[1] = enc(c_ldm, 3'd0, 3'd6, 5'd20);
        prog[2] = enc(c_std, 3'd5, 3'd6, 5'd0);
        prog[3] = enc(c_ldd, 3'd6, 3'd7, 5'd0);
        prog[4] = enc(c_add, 3'd5, 3'd7, 5'd0);
        prog[5] = enc(c_rti, 3'd0, 3'd0, 5'd0);
        prog[32] = enc(c_ldm, 3'd0, 3'd1, 5'd1);
        prog[33] = enc(c_ldm, 3'd0, 3'd2, 5'd0);
        for (int i = 34; i < 50; i++) begin
            prog[i] = enc(c_add, 3'd1, 3'd2, 5'd0);
        end
        prog[50] = enc(c_add, 3'd2, 3'd3, 5'd0);
        prog[51] = hlt_word;
        run_program("interrupt_rti", 1'b1);

        for (int p = 0; p < 4; p++) begin
            clear_prog();
            depth = 0;
            for (int k = 0; k < 26; k++) begin
                r = $random(seed);
                case (r[19:16])
                    4'd0:       op = c_nop;
                    4'd2:       op = c_not;
                    4'd3, 4'd4: op = c_add;
                    4'd5:       op = c_sub;
                    4'd6:       op = c_std;
                    4'd7, 4'd8: op = c_push;
                    4'd9, 4'd10: op = (depth > 0) ? c_pop : c_add;
                    4'd11:      op = 5'b11111;  // Undefined
                    default:    op = c_ldm;
                endcase
                if (op == c_push) begin
                    depth++;
                end else if (op == c_pop) begin
                    depth--;
                end
                prog[32 + k] = {op, r[10:0]};
            end
            prog[58] = hlt_word;
            run_program($sformatf("random_programs_%0d", p), 1'b0);
        end

        $display("%0d tests, %0d passed, %0d failed", tests, passed, tests - passed);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
source/cpu_pkg.sv
source/data_bus_if.sv
source/instr_mem.sv
source/reg_file.sv
source/data_mem.sv
source/pipe_core.sv
source/pipelined_processor.sv
tb/pipelined_processor_assert.sv
tb/pipelined_processor_tb.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator, then look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f --top-module pipelined_processor_tb &&
./obj_dir/Vpipelined_processor_tb | tee /dev/stderr | grep -q "TEST PASSED" &&
echo "Simulation succeeded" ||
{ echo "Simulation unsuccessful"; exit 1; }
